/* side_ch_iq_capture.f */
+incdir+common
common/side_ch_word_pkg.sv
common/side_ch_trig_pkg.sv
logic/iq_sample_pack.sv
trigger/iq_trigger_detect.sv
logic/iq_ring_buffer.sv
capture/iq_capture_fsm.sv
logic/side_ch_iq_capture.sv
tb/side_ch_iq_chk.sv
tb/side_ch_iq_scoreboard.sv
tb/tb_side_ch_iq_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the IQ capture testbench with Verilator, output goes to sim.log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	--top-module tb_side_ch_iq_capture \
	-f side_ch_iq_capture.f -o sim_tb

# an aborted run counts as a failure
./obj_dir/sim_tb > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

/* tb/tb_side_ch_iq_capture.sv */
// drives the rx source only; pre-trigger and length stay small so each capture ends quickly
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module tb_side_ch_iq_capture;

	logic                         clk;
	logic                         rstn;
	logic [`SC_GPIO_W-1:0]        gpio_status;
	logic signed [`SC_RSSI_W-1:0] rssi_half_db;
	logic signed [`SC_RSSI_W-1:0] rssi_th;
	logic [`SC_GPIO_W-2:0]        gain_th;
	logic [`SC_TSF_W-1:0]         tsf_runtime_val = '0;
	logic [31:0]                  rx_iq0 = '0;
	logic [31:0]                  rx_iq1 = '1;
	logic                         rx_strobe = 1'b0;
	logic [31:0]                  tx_iq0;
	logic [31:0]                  tx_iq1;
	logic                         tx_strobe;
	logic                         demod_is_ongoing;
	logic                         long_preamble_detected;
	logic                         short_preamble_detected;
	logic                         pkt_header_valid;
	logic                         pkt_header_valid_strobe;
	logic                         fcs_in_strobe;
	logic                         fcs_ok;
	logic                         phy_tx_done;
	logic                         tx_bb_is_ongoing;
	logic                         tx_rf_is_ongoing;
	logic                         iq_capture;
	logic                         iq_source_select;
	logic                         iq_capture_cfg;
	logic [4:0]                   iq_trigger_select;
	logic                         iq_trigger_free_run_flag;
	logic [`SC_LEN_W-1:0]         pre_trigger_len;
	logic [`SC_LEN_W-1:0]         iq_len;
	logic [`SC_LEN_W-1:0]         m_axis_data_count;
	logic [`SC_WORD_W-1:0]        data_to_ps;
	logic                         data_to_ps_valid;
	logic [31:0]                  seq = '0;
	logic [1:0]                   phase = '0;
	integer                       seed = 32'h7004;
	int test_cnt  = 0;
	int test_fail = 0;
	int timeouts  = 0;
	int base_capt;
	int base_drop;
	int base_err;
	int base_to;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// one rx sample every 4 cycles, tsf one per cycle
	always @(posedge clk) begin
		tsf_runtime_val <= tsf_runtime_val + 1'b1;
		phase           <= phase + 1'b1;
		rx_strobe       <= (phase == 2'd3);
		if (phase == 2'd3) begin
			rx_iq0 <= seq;
			rx_iq1 <= ~seq;
			seq    <= seq + 1'b1;
		end
	end

	side_ch_iq_capture i_dut (.*);

	side_ch_iq_scoreboard i_sb (.*);

	task automatic step(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic pick_lengths();
		int p;
		int l;
		p = 1 + ($unsigned($random(seed)) % 64);
		l = 1 + ($unsigned($random(seed)) % 32);
		@(posedge clk);
		pre_trigger_len <= p;
		iq_len          <= l;
	endtask

	task automatic pulse_fcs(input logic good);
		@(posedge clk);
		fcs_in_strobe <= 1'b1;
		fcs_ok        <= good;
		@(posedge clk);
		fcs_in_strobe <= 1'b0;
		fcs_ok        <= 1'b0;
	endtask

	task automatic pulse_tx_bb();
		@(posedge clk);
		tx_bb_is_ongoing <= 1'b1;
		@(posedge clk);
		tx_bb_is_ongoing <= 1'b0;
	endtask

	task automatic start_test();
		base_capt = i_sb.capt_cnt;
		base_drop = i_sb.drop_cnt;
		base_err  = i_sb.err_cnt;
		base_to   = timeouts;
	endtask

	task automatic wait_capture();
		int n;
		n = 0;
		while (i_sb.capt_cnt == base_capt && n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (i_sb.capt_cnt == base_capt) begin
			$display("timeout: no capture finished within 2000 cycles");
			timeouts++;
		end
	endtask

	task automatic wait_header();
		int n;
		n = 0;
		while (!data_to_ps_valid && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (!data_to_ps_valid) begin
			$display("timeout: no header beat within 100 cycles of the trigger");
			timeouts++;
		end
	endtask

	task automatic end_test(input string name, input int exp_capt, input int exp_drop);
		int got_capt;
		int got_drop;
		got_capt = i_sb.capt_cnt - base_capt;
		got_drop = i_sb.drop_cnt - base_drop;
		test_cnt++;
		if (got_capt == exp_capt && got_drop == exp_drop && i_sb.err_cnt == base_err &&
			timeouts == base_to) begin
			$display("test %0s: ok", name);
		end else begin
			test_fail++;
			$display("test %0s: FAILED with %0d captures and %0d drops, expected %0d and %0d",
				name, got_capt, got_drop, exp_capt, exp_drop);
		end
	endtask

	initial begin
		rstn = 1'b0;
		gpio_status = '0;
		rssi_half_db = -11'sd37;
		rssi_th = 11'sd20;
		gain_th = 7'd40;
		tx_iq0 = '0;
		tx_iq1 = '0;
		tx_strobe = 1'b0;
		demod_is_ongoing = 1'b0;
		long_preamble_detected = 1'b0;
		short_preamble_detected = 1'b0;
		pkt_header_valid = 1'b0;
		pkt_header_valid_strobe = 1'b0;
		fcs_in_strobe = 1'b0;
		fcs_ok = 1'b0;
		phy_tx_done = 1'b0;
		tx_bb_is_ongoing = 1'b0;
		tx_rf_is_ongoing = 1'b0;
		iq_capture = 1'b1;
		iq_source_select = 1'b0;
		iq_capture_cfg = 1'b0;
		iq_trigger_select = 5'd1;
		iq_trigger_free_run_flag = 1'b0;
		pre_trigger_len = 14'd16;
		iq_len = 14'd8;
		m_axis_data_count = '0;
		step(10);
		rstn <= 1'b1;

		start_test();
		step(2000);   // also fills the buffer
		end_test("idle without fcs", 0, 0);

		start_test();
		pick_lengths();
		pulse_fcs(1'b1);
		wait_capture();
		end_test("good fcs under fcs ok", 1, 0);

		start_test();
		pulse_fcs(1'b0);
		step(200);
		end_test("bad fcs under fcs ok", 0, 0);

		iq_trigger_select <= 5'd2;
		start_test();
		pick_lengths();
		pulse_fcs(1'b0);
		wait_capture();
		end_test("bad fcs under fcs fail", 1, 0);

		// status words, triggered by tx baseband start
		@(posedge clk);
		iq_trigger_select <= 5'd18;
		iq_capture_cfg    <= 1'b1;
		gpio_status       <= 8'hA5;
		demod_is_ongoing  <= 1'b1;
		tx_rf_is_ongoing  <= 1'b1;
		pulse_fcs(1'b1);
		step(400);
		start_test();
		pick_lengths();
		pulse_tx_bb();
		wait_capture();
		end_test("status words with fcs flag set", 1, 0);

		@(posedge clk);
		long_preamble_detected <= 1'b1;
		@(posedge clk);
		long_preamble_detected <= 1'b0;
		step(400);
		start_test();
		pick_lengths();
		pulse_tx_bb();
		wait_capture();
		end_test("status words with fcs flag cleared", 1, 0);

		@(posedge clk);
		iq_capture_cfg    <= 1'b0;
		demod_is_ongoing  <= 1'b0;
		tx_rf_is_ongoing  <= 1'b0;
		iq_trigger_select <= 5'd10;
		step(400);    // flush status words out of the pre-trigger window
		start_test();
		pick_lengths();
		@(posedge clk);
		rssi_half_db <= 11'sd30;
		wait_capture();
		step(600);
		end_test("rssi rising crossing held", 1, 0);

		@(posedge clk);
		rssi_half_db      <= -11'sd37;
		iq_trigger_select <= 5'd1;
		start_test();
		pick_lengths();
		@(posedge clk);
		m_axis_data_count <= `SC_MAX_UDP_WORDS - iq_len;  // one word short
		pulse_fcs(1'b1);
		step(100);
		end_test("trigger without downstream space", 0, 1);

		@(posedge clk);
		m_axis_data_count <= `SC_MAX_UDP_WORDS - iq_len - 1;
		start_test();
		pulse_fcs(1'b1);
		wait_capture();
		end_test("trigger with exact downstream space", 1, 0);

		// drop the enable while samples stream out
		@(posedge clk);
		m_axis_data_count <= '0;
		iq_len            <= 14'd32;
		start_test();
		pulse_fcs(1'b1);
		wait_header();
		iq_capture <= 1'b0;
		step(20);
		pulse_fcs(1'b1);   // ignored while disabled
		step(20);
		iq_capture <= 1'b1;
		step(200);
		end_test("capture disabled mid stream", 0, 0);

		step(20);
		$display("%0d tests, %0d failed, %0d check errors, %0d timeouts",
			test_cnt, test_fail, i_sb.err_cnt, timeouts);
		if (test_fail == 0 && i_sb.err_cnt == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* tb/side_ch_iq_scoreboard.sv */
// predicts captures for trigger codes 0, 1, 2, 10 and 18 on the rx source; free run not modeled
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module side_ch_iq_scoreboard (
	input logic                         clk,
	input logic                         rstn,
	input logic                         iq_capture,
	input logic                         iq_capture_cfg,
	input logic [4:0]                   iq_trigger_select,
	input logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input logic signed [`SC_RSSI_W-1:0] rssi_th,
	input logic [`SC_GPIO_W-1:0]        gpio_status,
	input logic                         demod_is_ongoing,
	input logic                         tx_rf_is_ongoing,
	input logic                         tx_bb_is_ongoing,
	input logic                         fcs_in_strobe,
	input logic                         fcs_ok,
	input logic                         long_preamble_detected,
	input logic [31:0]                  rx_iq0,
	input logic [`SC_TSF_W-1:0]         tsf_runtime_val,
	input logic [`SC_LEN_W-1:0]         pre_trigger_len,
	input logic [`SC_LEN_W-1:0]         iq_len,
	input logic [`SC_LEN_W-1:0]         m_axis_data_count,
	input logic [`SC_WORD_W-1:0]        data_to_ps,
	input logic                         data_to_ps_valid
);

	int err_cnt  = 0;
	int capt_cnt = 0;
	int drop_cnt = 0;

	logic signed [`SC_RSSI_W-1:0] rssi_prev;
	logic                         tx_bb_prev;
	logic                         fcs_flag;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_prev  <= '0;
			tx_bb_prev <= 1'b0;
			fcs_flag   <= 1'b0;
		end else begin
			rssi_prev  <= rssi_half_db;
			tx_bb_prev <= tx_bb_is_ongoing;
			if (fcs_in_strobe && fcs_ok)
				fcs_flag <= 1'b1;
			else if (long_preamble_detected)
				fcs_flag <= 1'b0;   // next packet begins
		end
	end

	function automatic logic event_fires(input logic [4:0] sel);
		case (sel)
			5'd0:    return fcs_in_strobe;
			5'd1:    return fcs_in_strobe && fcs_ok;
			5'd2:    return fcs_in_strobe && !fcs_ok;
			5'd10:   return (rssi_prev < rssi_th) && (rssi_half_db >= rssi_th);
			5'd18:   return tx_bb_is_ongoing && !tx_bb_prev;
			default: return 1'b0;
		endcase
	endfunction

	// reference word: {ant1, ant0} or {status, gpio, ant0}
	function automatic logic [`SC_WORD_W-1:0] expected_word(input logic [31:0] seq,
		input logic fmt, input logic [`SC_RSSI_W-1:0] rssi, input logic [`SC_GPIO_W-1:0] gpio,
		input logic demod, input logic txrf, input logic flag);
		if (fmt)
			return {demod, txrf, flag, 5'b0, {(16-`SC_RSSI_W){rssi[`SC_RSSI_W-1]}}, rssi,
				gpio, seq};
		return {~seq, seq};
	endfunction

	task automatic report_mismatch(input string msg);
		$display("ERR %0t: %0s", $time, msg);
		err_cnt++;
	endtask

	task automatic wait_valid(input int limit, output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < limit) begin
			@(posedge clk);
			if (!iq_capture)
				return;    // capture cut short by the enable
			seen = data_to_ps_valid;
			n++;
		end
	endtask

	task automatic check_capture();
		logic [`SC_WORD_W-1:0] exp_hdr;
		logic [`SC_WORD_W-1:0] exp_word;
		logic [31:0]           ev_seq;
		logic [31:0]           first_seq;
		logic [`SC_RSSI_W-1:0] rssi;
		logic [`SC_GPIO_W-1:0] gpio;
		logic                  fmt;
		logic                  demod;
		logic                  txrf;
		logic                  flag;
		logic                  seen;
		int                    pre;
		int                    len;
		int                    diff;
		exp_hdr = tsf_runtime_val + 1'b1;   // latched one cycle after the event
		ev_seq  = rx_iq0;
		pre     = pre_trigger_len;
		len     = iq_len;
		fmt     = iq_capture_cfg;
		rssi    = rssi_half_db;
		gpio    = gpio_status;
		demod   = demod_is_ongoing;
		txrf    = tx_rf_is_ongoing;
		flag    = fcs_flag;
		if (`SC_MAX_UDP_WORDS - int'(m_axis_data_count) < len + 1) begin
			repeat (40) begin
				@(posedge clk);
				if (data_to_ps_valid)
					report_mismatch("output beat after a trigger without downstream space");
			end
			drop_cnt++;
			return;
		end
		wait_valid(20, seen);
		if (!iq_capture)
			return;
		if (!seen) begin
			$display("no header beat arrived within 20 cycles of the trigger");
			err_cnt++;
			return;
		end
		if (data_to_ps !== exp_hdr)
			report_mismatch($sformatf("header %h, expected %h", data_to_ps, exp_hdr));
		first_seq = '0;
		for (int k = 0; k < len; k++) begin
			wait_valid(40, seen);
			if (!iq_capture)
				return;
			if (!seen) begin
				$display("sample %0d of %0d never arrived, the stream stalled", k, len);
				err_cnt++;
				return;
			end
			if (k == 0) begin
				first_seq = data_to_ps[31:0];
				diff      = int'(first_seq) - (int'(ev_seq) - pre);
				if (diff < -1 || diff > 1)
					report_mismatch($sformatf("first sample %0d, event %0d, pre %0d",
						first_seq, ev_seq, pre));
			end
			exp_word = expected_word(first_seq + k, fmt, rssi, gpio, demod, txrf, flag);
			if (data_to_ps !== exp_word)
				report_mismatch($sformatf("sample %0d is %h, expected %h", k, data_to_ps,
					exp_word));
		end
		capt_cnt++;
	endtask

	initial begin : compare
		forever begin
			@(posedge clk);
			if (!rstn || !iq_capture)
				continue;
			if (data_to_ps_valid)
				report_mismatch("valid beat with no capture pending");
			if (event_fires(iq_trigger_select))
				check_capture();
		end
	end

endmodule

/* tb/side_ch_iq_chk.sv */
// bound into the top level; relies on the top's internal sample_strobe wire
`timescale 1ns/1ps

module side_ch_iq_chk (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input logic sample_strobe,
	input logic data_to_ps_valid
);

	a_valid_in_reset: assert property (@(posedge clk) !rstn |=> !data_to_ps_valid)
		else $error("output valid high after a reset cycle");

	a_valid_disabled: assert property (@(posedge clk) !iq_capture |=> !data_to_ps_valid)
		else $error("output valid high while capture is disabled");

	// back to back beats only when a sample arrived in between
	a_beat_spacing: assert property (@(posedge clk) disable iff (!rstn)
		data_to_ps_valid |=> (!data_to_ps_valid || $past(sample_strobe)))
		else $error("valid beat without a sample strobe");

endmodule

bind side_ch_iq_capture side_ch_iq_chk i_chk (
	.clk(clk),
	.rstn(rstn),
	.iq_capture(iq_capture),
	.sample_strobe(sample_strobe),
	.data_to_ps_valid(data_to_ps_valid)
);

/* logic/side_ch_iq_capture.sv */
// IQ capture top; trigger codes outside the supported set never fire
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module side_ch_iq_capture
	import side_ch_word_pkg::*;
	import side_ch_trig_pkg::*;
(
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [`SC_GPIO_W-1:0]        gpio_status,
	input  logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input  logic [`SC_TSF_W-1:0]         tsf_runtime_val,
	input  iq_pair_t                     rx_iq0,
	input  iq_pair_t                     rx_iq1,
	input  logic                         rx_strobe,
	input  iq_pair_t                     tx_iq0,
	input  iq_pair_t                     tx_iq1,
	input  logic                         tx_strobe,
	input  logic                         demod_is_ongoing,
	input  logic                         long_preamble_detected,
	input  logic                         short_preamble_detected,
	input  logic                         pkt_header_valid,
	input  logic                         pkt_header_valid_strobe,
	input  logic                         fcs_in_strobe,
	input  logic                         fcs_ok,
	input  logic                         phy_tx_done,
	input  logic                         tx_bb_is_ongoing,
	input  logic                         tx_rf_is_ongoing,
	input  logic                         iq_capture,          // capture enable
	input  logic                         iq_source_select,
	input  logic                         iq_capture_cfg,      // 1 packs status words
	input  logic [4:0]                   iq_trigger_select,
	input  logic                         iq_trigger_free_run_flag,
	input  logic signed [`SC_RSSI_W-1:0] rssi_th,
	input  logic [`SC_GPIO_W-2:0]        gain_th,
	input  logic [`SC_LEN_W-1:0]         pre_trigger_len,
	input  logic [`SC_LEN_W-1:0]         iq_len,
	input  logic [`SC_LEN_W-1:0]         m_axis_data_count,
	output logic [`SC_WORD_W-1:0]        data_to_ps,
	output logic                         data_to_ps_valid
);

	buf_word_u buf_word;
	buf_word_u rd_word;
	logic      sample_strobe;
	logic      trig;
	logic      mark;
	logic      advance;

	iq_sample_pack i_pack (
		.clk(clk), .rstn(rstn), .src_sel(iq_source_select),
		.rx_iq0(rx_iq0), .rx_iq1(rx_iq1), .rx_strobe(rx_strobe),
		.tx_iq0(tx_iq0), .tx_iq1(tx_iq1), .tx_strobe(tx_strobe),
		.fmt_status(iq_capture_cfg), .gpio_status(gpio_status), .rssi_half_db(rssi_half_db),
		.demod_is_ongoing(demod_is_ongoing), .tx_rf_is_ongoing(tx_rf_is_ongoing),
		.fcs_in_strobe(fcs_in_strobe), .fcs_ok(fcs_ok),
		.long_preamble_detected(long_preamble_detected),
		.buf_word(buf_word), .sample_strobe(sample_strobe)
	);

	iq_trigger_detect i_trig (
		.clk(clk), .rstn(rstn), .cap_en(iq_capture),
		.trig_sel(trig_sel_e'(iq_trigger_select)), .free_run(iq_trigger_free_run_flag),
		.rssi_half_db(rssi_half_db), .rssi_th(rssi_th),
		.gpio_status(gpio_status), .gain_th(gain_th),
		.fcs_in_strobe(fcs_in_strobe), .fcs_ok(fcs_ok),
		.pkt_header_valid(pkt_header_valid), .pkt_header_valid_strobe(pkt_header_valid_strobe),
		.long_preamble_detected(long_preamble_detected),
		.short_preamble_detected(short_preamble_detected),
		.phy_tx_done(phy_tx_done), .tx_bb_is_ongoing(tx_bb_is_ongoing),
		.tx_rf_is_ongoing(tx_rf_is_ongoing), .trig(trig)
	);

	iq_ring_buffer i_buf (
		.clk(clk), .rstn(rstn), .cap_en(iq_capture),
		.wr_en(sample_strobe), .wr_word(buf_word),
		.mark(mark), .advance(advance), .pre_trigger_len(pre_trigger_len),
		.rd_word(rd_word)
	);

	iq_capture_fsm i_fsm (
		.clk(clk), .rstn(rstn), .cap_en(iq_capture), .trig(trig),
		.sample_strobe(sample_strobe), .tsf_runtime_val(tsf_runtime_val),
		.iq_len(iq_len), .m_axis_data_count(m_axis_data_count), .rd_word(rd_word),
		.mark(mark), .advance(advance),
		.data_to_ps(data_to_ps), .data_to_ps_valid(data_to_ps_valid)
	);

endmodule

/* capture/iq_capture_fsm.sv */
// no back-pressure once the header is out; beats follow sample_strobe at the sample rate
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module iq_capture_fsm
	import side_ch_word_pkg::*;
	import side_ch_trig_pkg::*;
(
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  cap_en,
	input  logic                  trig,
	input  logic                  sample_strobe,
	input  logic [`SC_TSF_W-1:0]  tsf_runtime_val,
	input  logic [`SC_LEN_W-1:0]  iq_len,
	input  logic [`SC_LEN_W-1:0]  m_axis_data_count,
	input  buf_word_u             rd_word,
	output logic                  mark,
	output logic                  advance,
	output logic [`SC_WORD_W-1:0] data_to_ps,
	output logic                  data_to_ps_valid
);

	cap_state_e             state;
	logic [`SC_TSF_W-1:0]   tsf_lock;
	logic [`SC_LEN_W-1:0]   beat_cnt;
	logic [`SC_LEN_W+1:0]   need_words;
	logic                   space_ok;

	assign mark    = cap_en && (state == CAP_WAIT) && trig;
	assign advance = cap_en && (state == CAP_STREAM) && sample_strobe;

	// words already queued plus header plus samples must fit one datagram
	assign need_words = {2'b00, m_axis_data_count} + {2'b00, iq_len} + 1'b1;
	assign space_ok   = (need_words <= `SC_MAX_UDP_WORDS);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state            <= CAP_WAIT;
			beat_cnt         <= '0;
			data_to_ps_valid <= 1'b0;
		end else if (!cap_en) begin
			state            <= CAP_WAIT;
			data_to_ps_valid <= 1'b0;
		end else begin
			data_to_ps_valid <= 1'b0;
			case (state)
				CAP_WAIT: begin
					beat_cnt <= '0;
					if (trig)
						state <= CAP_PREPARE;
				end
				CAP_PREPARE: begin
					if (space_ok) begin
						data_to_ps_valid <= 1'b1;  // header beat
						state            <= CAP_HEADER;
					end else begin
						state <= CAP_WAIT;       // drop, nothing sent
					end
				end
				CAP_HEADER:
					state <= (iq_len == '0) ? CAP_WAIT : CAP_STREAM;
				CAP_STREAM: begin
					if (sample_strobe) begin
						data_to_ps_valid <= 1'b1;
						beat_cnt         <= beat_cnt + 1'b1;
						if (beat_cnt == iq_len - 1'b1)
							state <= CAP_WAIT;
					end
				end
			endcase
		end
	end

	// timestamp and payload
	always_ff @(posedge clk) begin
		if (mark)
			tsf_lock <= tsf_runtime_val;
		if (state == CAP_PREPARE)
			data_to_ps <= tsf_lock;
		else if (advance)
			data_to_ps <= rd_word;
	end

endmodule

/* logic/iq_ring_buffer.sv */
// memory has no reset; pre_trigger_len should be 1..8191 so the first word read is already written
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module iq_ring_buffer import side_ch_word_pkg::*; (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 cap_en,
	input  logic                 wr_en,
	input  buf_word_u            wr_word,
	input  logic                 mark,      // rewind read side behind the write pointer
	input  logic                 advance,
	input  logic [`SC_LEN_W-1:0] pre_trigger_len,
	output buf_word_u            rd_word
);

	localparam int DEPTH = 1 << `SC_BUF_AW;

	buf_word_u              mem [DEPTH];
	logic [`SC_BUF_AW-1:0]  wr_ptr;
	logic [`SC_BUF_AW-1:0]  rd_ptr;

	// both pointers wrap naturally at the depth
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (cap_en) begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (mark)
				rd_ptr <= wr_ptr - pre_trigger_len[`SC_BUF_AW-1:0];
			else if (advance)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cap_en && wr_en)
			mem[wr_ptr] <= wr_word;
		rd_word <= mem[rd_ptr];  // one cycle read latency
	end

endmodule

/* trigger/iq_trigger_detect.sv */
// one register from the event edge to trig; crossings compare against last cycle's inputs
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module iq_trigger_detect import side_ch_trig_pkg::*; (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         cap_en,
	input  trig_sel_e                    trig_sel,
	input  logic                         free_run,
	input  logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input  logic signed [`SC_RSSI_W-1:0] rssi_th,
	input  logic [`SC_GPIO_W-1:0]        gpio_status,
	input  logic [`SC_GPIO_W-2:0]        gain_th,
	input  logic                         fcs_in_strobe,
	input  logic                         fcs_ok,
	input  logic                         pkt_header_valid,
	input  logic                         pkt_header_valid_strobe,
	input  logic                         long_preamble_detected,
	input  logic                         short_preamble_detected,
	input  logic                         phy_tx_done,
	input  logic                         tx_bb_is_ongoing,
	input  logic                         tx_rf_is_ongoing,
	output logic                         trig
);

	logic signed [`SC_RSSI_W-1:0] rssi_prev;
	logic [`SC_GPIO_W-1:0]        gpio_prev;
	logic                         tx_bb_prev;
	logic                         tx_rf_prev;
	logic [`SC_GPIO_W-2:0]        gain_now;
	logic [`SC_GPIO_W-2:0]        gain_prev;
	logic                         agc_now;
	logic                         agc_prev;
	logic                         evt;

	assign gain_now  = gpio_status[`SC_GPIO_W-2:0];
	assign gain_prev = gpio_prev[`SC_GPIO_W-2:0];
	assign agc_now   = gpio_status[`SC_GPIO_W-1];
	assign agc_prev  = gpio_prev[`SC_GPIO_W-1];

	// last cycle's levels for the crossing detectors
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_prev  <= '0;
			gpio_prev  <= '0;
			tx_bb_prev <= 1'b0;
			tx_rf_prev <= 1'b0;
		end else begin
			rssi_prev  <= rssi_half_db;
			gpio_prev  <= gpio_status;
			tx_bb_prev <= tx_bb_is_ongoing;
			tx_rf_prev <= tx_rf_is_ongoing;
		end
	end

	always_comb begin
		case (trig_sel)
			TRIG_FCS_ANY:        evt = fcs_in_strobe | free_run;
			TRIG_FCS_OK:         evt = fcs_in_strobe & fcs_ok;
			TRIG_FCS_FAIL:       evt = fcs_in_strobe & ~fcs_ok;
			TRIG_HDR_VALID:      evt = pkt_header_valid_strobe & pkt_header_valid;
			TRIG_HDR_INVALID:    evt = pkt_header_valid_strobe & ~pkt_header_valid;
			TRIG_LONG_PREAMBLE:  evt = long_preamble_detected;
			TRIG_SHORT_PREAMBLE: evt = short_preamble_detected;
			TRIG_RSSI_RISE:      evt = (rssi_prev < rssi_th) && (rssi_half_db >= rssi_th);
			TRIG_RSSI_FALL:      evt = (rssi_prev >= rssi_th) && (rssi_half_db < rssi_th);
			TRIG_AGC_LOST:       evt = agc_prev & ~agc_now;
			TRIG_AGC_LOCKED:     evt = ~agc_prev & agc_now;
			TRIG_GAIN_RISE:      evt = (gain_prev < gain_th) && (gain_now >= gain_th);
			TRIG_GAIN_FALL:      evt = (gain_prev >= gain_th) && (gain_now < gain_th);
			TRIG_TX_DONE:        evt = phy_tx_done;
			TRIG_TX_BB_START:    evt = tx_bb_is_ongoing & ~tx_bb_prev;
			TRIG_TX_BB_END:      evt = ~tx_bb_is_ongoing & tx_bb_prev;
			TRIG_TX_RF_START:    evt = tx_rf_is_ongoing & ~tx_rf_prev;
			TRIG_TX_RF_END:      evt = ~tx_rf_is_ongoing & tx_rf_prev;
			default:             evt = 1'b0;    // unsupported codes stay quiet
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			trig <= 1'b0;
		else
			trig <= cap_en & evt;
	end

endmodule

/* logic/iq_sample_pack.sv */
// buffer word is combinational; src_sel and fmt_status should not change during a capture
`include "side_ch_settings.svh"
`timescale 1ns/1ps

module iq_sample_pack import side_ch_word_pkg::*; (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        src_sel,    // 0 receiver, 1 tx interface
	input  iq_pair_t                    rx_iq0,
	input  iq_pair_t                    rx_iq1,
	input  logic                        rx_strobe,
	input  iq_pair_t                    tx_iq0,
	input  iq_pair_t                    tx_iq1,
	input  logic                        tx_strobe,
	input  logic                        fmt_status, // 1 selects the stat view
	input  logic [`SC_GPIO_W-1:0]       gpio_status,
	input  logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input  logic                        demod_is_ongoing,
	input  logic                        tx_rf_is_ongoing,
	input  logic                        fcs_in_strobe,
	input  logic                        fcs_ok,
	input  logic                        long_preamble_detected,
	output buf_word_u                   buf_word,
	output logic                        sample_strobe
);

	logic     fcs_ok_flag;
	iq_pair_t sel_iq0;
	iq_pair_t sel_iq1;

	assign sel_iq0       = src_sel ? tx_iq0 : rx_iq0;
	assign sel_iq1       = src_sel ? tx_iq1 : rx_iq1;
	assign sample_strobe = src_sel ? tx_strobe : rx_strobe;

	// set by a good fcs, dropped when the next packet starts decoding
	always_ff @(posedge clk) begin
		if (!rstn)
			fcs_ok_flag <= 1'b0;
		else if (fcs_in_strobe && fcs_ok)
			fcs_ok_flag <= 1'b1;
		else if (long_preamble_detected)
			fcs_ok_flag <= 1'b0;
	end

	always_comb begin
		buf_word = '0;
		if (fmt_status) begin
			buf_word.stat.status.demod_ongoing = demod_is_ongoing;
			buf_word.stat.status.tx_rf_ongoing = tx_rf_is_ongoing;
			buf_word.stat.status.fcs_ok        = fcs_ok_flag;
			buf_word.stat.status.rssi          =
				{{(16-`SC_RSSI_W){rssi_half_db[`SC_RSSI_W-1]}}, rssi_half_db};
			buf_word.stat.gpio = gpio_status;
			buf_word.stat.ant0 = sel_iq0;
		end else begin
			buf_word.dual.ant1 = sel_iq1;  // antenna 1 in the upper half
			buf_word.dual.ant0 = sel_iq0;
		end
	end

endmodule

/* common/side_ch_trig_pkg.sv */
// trigger codes keep the numbering of the full controller; codes not listed never fire

package side_ch_trig_pkg;

	typedef enum logic [4:0] {
		TRIG_FCS_ANY        = 5'd0,    // also free run
		TRIG_FCS_OK         = 5'd1,
		TRIG_FCS_FAIL       = 5'd2,
		TRIG_HDR_VALID      = 5'd4,
		TRIG_HDR_INVALID    = 5'd5,
		TRIG_LONG_PREAMBLE  = 5'd8,
		TRIG_SHORT_PREAMBLE = 5'd9,
		TRIG_RSSI_RISE      = 5'd10,
		TRIG_RSSI_FALL      = 5'd11,
		TRIG_AGC_LOST       = 5'd12,   // lock to unlock
		TRIG_AGC_LOCKED     = 5'd13,   // unlock to lock
		TRIG_GAIN_RISE      = 5'd14,
		TRIG_GAIN_FALL      = 5'd15,
		TRIG_TX_DONE        = 5'd17,
		TRIG_TX_BB_START    = 5'd18,
		TRIG_TX_BB_END      = 5'd19,
		TRIG_TX_RF_START    = 5'd20,
		TRIG_TX_RF_END      = 5'd21
	} trig_sel_e;

	// capture sequencer
	typedef enum logic [1:0] {
		CAP_WAIT,
		CAP_PREPARE,
		CAP_HEADER,
		CAP_STREAM
	} cap_state_e;

endpackage

/* common/side_ch_word_pkg.sv */
// buffer word layouts; the stat view keeps RSSI sign-extended to 16 bits and five zero bits
`include "side_ch_settings.svh"

package side_ch_word_pkg;

	// one complex sample, q in the upper half
	typedef struct packed {
		logic [`SC_IQ_W-1:0] q;
		logic [`SC_IQ_W-1:0] i;
	} iq_pair_t;

	typedef struct packed {
		logic        demod_ongoing;
		logic        tx_rf_ongoing;
		logic        fcs_ok;
		logic [4:0]  rsvd;    // always zero
		logic [15:0] rssi;    // half dB, sign-extended
	} sc_status_t;

	typedef struct packed {
		iq_pair_t ant1;
		iq_pair_t ant0;
	} dual_view_t;

	typedef struct packed {
		sc_status_t              status;
		logic [`SC_GPIO_W-1:0]   gpio;
		iq_pair_t                ant0;
	} stat_view_t;

	// same 64 bits, decoded by the capture format bit
	typedef union packed {
		dual_view_t dual;
		stat_view_t stat;
	} buf_word_u;

endpackage

/* common/side_ch_settings.svh */
// shared widths and limits; SC_MAX_UDP_WORDS must stay below 2**SC_LEN_W and the buffer depth
`ifndef SIDE_CH_SETTINGS_SVH
`define SIDE_CH_SETTINGS_SVH

// sample and word widths
`define SC_IQ_W          16
`define SC_TSF_W         64
`define SC_WORD_W        64

// status inputs
`define SC_GPIO_W        8     // msb agc lock, lower bits gain
`define SC_RSSI_W        11    // signed, half dB steps

// buffer and length fields
`define SC_BUF_AW        13    // 8192 words
`define SC_LEN_W         14

// one UDP datagram of 64-bit words
`define SC_MAX_UDP_WORDS 8188

`endif
